// File: include/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// address and pc width
`define XLEN 32

// one cache block is one memory beat
`define BLOCK_BITS 64

// direct mapped geometry over a 64 KiB space
`define CACHE_LINES 32
`define CACHE_IDX_BITS 5
`define CACHE_TAG_BITS 8

// byte offset inside a block
`define BLOCK_OFS_BITS 3

// bus transaction tag, zero is reserved
`define MEM_TAG_BITS 4

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

// File: hdl/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

	typedef logic [`XLEN-1:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [`BLOCK_BITS-1:0] block_t;
	typedef logic [`CACHE_IDX_BITS-1:0] cache_idx_t;
	typedef logic [`CACHE_TAG_BITS-1:0] cache_tag_t;
	// zero means no transaction
	typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

	typedef enum logic [1:0] {
		BUS_NONE = 2'h0,
		BUS_LOAD = 2'h1
	} mem_cmd_t;

	// line index sits just above the block offset
	function automatic cache_idx_t addr_idx(input addr_t a);
		return a[`CACHE_IDX_BITS+`BLOCK_OFS_BITS-1:`BLOCK_OFS_BITS];
	endfunction

	// tag is the rest of the 64 KiB space, upper bits ignored
	function automatic cache_tag_t addr_tag(input addr_t a);
		return a[`CACHE_TAG_BITS+`CACHE_IDX_BITS+`BLOCK_OFS_BITS-1:
			`CACHE_IDX_BITS+`BLOCK_OFS_BITS];
	endfunction

endpackage

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_stage (
	input  logic             clock,
	input  logic             rst,
	input  logic             stall,
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_pc,
	input  logic             inst_ready,
	input  fetch_pkg::block_t rd_data,
	output fetch_pkg::addr_t fetch_addr,
	output logic             if_valid,
	output fetch_pkg::addr_t if_pc,
	output fetch_pkg::addr_t if_npc,
	output fetch_pkg::inst_t if_inst
);

	import fetch_pkg::*;

	////////////////////////////////
	// pc and next pc
	////////////////////////////////

	addr_t pc;
	addr_t pc_plus4;
	inst_t word_sel;
	logic  advance;

	assign pc_plus4 = pc + `XLEN'd4;

	// cache looks up the current pc directly
	assign fetch_addr = pc;

	// bit 2 picks the word inside the 8 byte block
	assign word_sel = pc[2] ? rd_data[`BLOCK_BITS-1:32] : rd_data[31:0];

	// a packet leaves only on a hit with no stall and no redirect
	assign advance = inst_ready && !stall && !redirect;

	// control state
	always_ff @(posedge clock) begin
		if (rst) begin
			pc       <= `RESET_PC;
			if_valid <= 1'b0;
		end else if (redirect) begin
			// redirect wins over stall
			// packet in flight is from the old path
			pc       <= redirect_pc;
			if_valid <= 1'b0;
		end else if (stall) begin
			// back pressure, hold everything
			pc       <= pc;
			if_valid <= if_valid;
		end else if (inst_ready) begin
			pc       <= pc_plus4;
			if_valid <= 1'b1;
		end else begin
			// miss, wait on the same pc
			if_valid <= 1'b0;
		end
	end

	////////////////////////////////
	// packet payload
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (advance) begin
			if_pc   <= pc;
			if_npc  <= pc_plus4;
			if_inst <= word_sel;
		end
	end

	// redirect targets and the reset vector are word aligned
	a_pc_aligned: assert property (
		@(posedge clock) disable iff (rst)
		pc[1:0] == 2'b00
	) else $error("fetch pc not word aligned %h", pc);

endmodule

// File: hdl/icache_ctrl.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module icache_ctrl (
	input  logic                 clock,
	input  logic                 rst,
	input  fetch_pkg::addr_t     fetch_addr,
	input  logic                 rd_hit,
	input  fetch_pkg::mem_tag_t  mem2proc_response,
	input  fetch_pkg::mem_tag_t  mem2proc_tag,
	output logic                 inst_ready,
	output fetch_pkg::mem_cmd_t  proc2mem_command,
	output fetch_pkg::addr_t     proc2mem_addr,
	output logic                 wr_en,
	output fetch_pkg::cache_idx_t wr_idx,
	output fetch_pkg::cache_tag_t wr_tag
);

	import fetch_pkg::*;

	////////////////////////////////
	// outstanding request
	////////////////////////////////

	logic       pending;
	mem_tag_t   pend_tag;
	cache_idx_t pend_idx;
	cache_tag_t pend_line_tag;

	logic accepted;
	logic fill;
	logic want_load;

	// hit goes straight back to fetch
	assign inst_ready = rd_hit;

	// memory took this cycle's load when it answers nonzero
	assign accepted = (proc2mem_command == BUS_LOAD) && (mem2proc_response != '0);

	// returning beat matches the saved tag
	// tag zero on the bus means nothing returns
	assign fill = (mem2proc_tag != '0) && (mem2proc_tag == pend_tag);

	// issue on a miss once the bus is free
	// a refused load comes back here and retries
	assign want_load = !rd_hit && !pending && !accepted;

	////////////////////////////////
	// bus side
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			proc2mem_command <= BUS_NONE;
			pending          <= 1'b0;
		end else begin
			proc2mem_command <= want_load ? BUS_LOAD : BUS_NONE;
			if (accepted)
				pending <= 1'b1;
			else if (fill)
				pending <= 1'b0;
		end
	end

	// request address and saved line coordinates
	always_ff @(posedge clock) begin
		// block aligned request for the current pc
		if (want_load)
			proc2mem_addr <= {fetch_addr[`XLEN-1:`BLOCK_OFS_BITS], `BLOCK_OFS_BITS'b0};
		// line is taken from the request itself, so a redirect
		// while in flight still fills the right line
		if (accepted) begin
			pend_tag      <= mem2proc_response;
			pend_idx      <= addr_idx(proc2mem_addr);
			pend_line_tag <= addr_tag(proc2mem_addr);
		end
	end

	////////////////////////////////
	// cache write side
	////////////////////////////////

	// data itself comes straight off the bus
	assign wr_en  = fill;
	assign wr_idx = pend_idx;
	assign wr_tag = pend_line_tag;

	// one outstanding load at a time
	a_single_load: assert property (
		@(posedge clock) disable iff (rst)
		(proc2mem_command == BUS_LOAD) |-> !pending
	) else $error("load issued with a request pending");

	// a saved tag coming back with nothing pending is a stale beat
	a_fill_pending: assert property (
		@(posedge clock) disable iff (rst)
		wr_en |-> pending
	) else $error("cache write without a pending request");

endmodule

// File: hdl/icache_mem.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module icache_mem (
	input  logic                  clock,
	input  logic                  rst,
	input  fetch_pkg::addr_t      fetch_addr,
	input  logic                  wr_en,
	input  fetch_pkg::cache_idx_t wr_idx,
	input  fetch_pkg::cache_tag_t wr_tag,
	input  fetch_pkg::block_t     wr_data,
	output fetch_pkg::block_t     rd_data,
	output logic                  rd_hit
);

	import fetch_pkg::*;

	////////////////////////////////
	// line storage
	////////////////////////////////

	logic [`CACHE_LINES-1:0] line_valid;
	cache_tag_t line_tag [`CACHE_LINES];
	block_t     line_data [`CACHE_LINES];

	cache_idx_t rd_idx;
	cache_tag_t rd_tag;

	assign rd_idx = addr_idx(fetch_addr);
	assign rd_tag = addr_tag(fetch_addr);

	// combinational lookup
	assign rd_data = line_data[rd_idx];
	assign rd_hit  = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);

	// valid bits, all lines empty after reset
	always_ff @(posedge clock) begin
		if (rst)
			line_valid <= '0;
		else if (wr_en)
			line_valid[wr_idx] <= 1'b1;
	end

	// tag and block arrays
	always_ff @(posedge clock) begin
		if (wr_en) begin
			line_tag[wr_idx]  <= wr_tag;
			line_data[wr_idx] <= wr_data;
		end
	end

	// an unknown index would smear the write over the array
	a_wr_idx_known: assert property (
		@(posedge clock) disable iff (rst)
		wr_en |-> !$isunknown(wr_idx)
	) else $error("cache write with unknown index");

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
	input  logic                clock,
	input  logic                rst,
	input  logic                stall,
	input  logic                redirect,
	input  fetch_pkg::addr_t    redirect_pc,
	input  fetch_pkg::mem_tag_t mem2proc_response,
	input  fetch_pkg::mem_tag_t mem2proc_tag,
	input  fetch_pkg::block_t   mem2proc_data,
	output fetch_pkg::mem_cmd_t proc2mem_command,
	output fetch_pkg::addr_t    proc2mem_addr,
	output logic                if_valid,
	output fetch_pkg::addr_t    if_pc,
	output fetch_pkg::addr_t    if_npc,
	output fetch_pkg::inst_t    if_inst
);

	import fetch_pkg::*;

	////////////////////////////////
	// internal nets
	////////////////////////////////

	// fetch to cache lookup
	addr_t  fetch_addr;
	block_t rd_data;
	logic   rd_hit;
	logic   inst_ready;

	// controller to cache write port
	logic       wr_en;
	cache_idx_t wr_idx;
	cache_tag_t wr_tag;

	fetch_stage u_fetch (
		.clock       (clock),
		.rst         (rst),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.inst_ready  (inst_ready),
		.rd_data     (rd_data),
		.fetch_addr  (fetch_addr),
		.if_valid    (if_valid),
		.if_pc       (if_pc),
		.if_npc      (if_npc),
		.if_inst     (if_inst)
	);

	icache_ctrl u_ctrl (
		.clock             (clock),
		.rst               (rst),
		.fetch_addr        (fetch_addr),
		.rd_hit            (rd_hit),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.inst_ready        (inst_ready),
		.proc2mem_command  (proc2mem_command),
		.proc2mem_addr     (proc2mem_addr),
		.wr_en             (wr_en),
		.wr_idx            (wr_idx),
		.wr_tag            (wr_tag)
	);

	// fill data goes straight from the bus into the array
	icache_mem u_mem (
		.clock      (clock),
		.rst        (rst),
		.fetch_addr (fetch_addr),
		.wr_en      (wr_en),
		.wr_idx     (wr_idx),
		.wr_tag     (wr_tag),
		.wr_data    (mem2proc_data),
		.rd_data    (rd_data),
		.rd_hit     (rd_hit)
	);

endmodule

// File: tests/mem_model.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module mem_model (
	input  logic                clock,
	input  logic                rst,
	input  fetch_pkg::mem_cmd_t proc2mem_command,
	input  fetch_pkg::addr_t    proc2mem_addr,
	output fetch_pkg::mem_tag_t mem2proc_response,
	output fetch_pkg::mem_tag_t mem2proc_tag,
	output fetch_pkg::block_t   mem2proc_data,
	output int unsigned         accept_count
);

	import fetch_pkg::*;

	////////////////////////////////
	// acceptance
	////////////////////////////////

	// drawn once per cycle so about one load in four is turned away
	logic        refuse;
	mem_tag_t    next_tag;
	logic        busy;
	mem_tag_t    busy_tag;
	addr_t       busy_addr;
	int unsigned wait_cnt;

	always_comb begin
		if (proc2mem_command == BUS_LOAD && !refuse && !busy)
			mem2proc_response = next_tag;
		else
			mem2proc_response = '0;
	end

	// instruction at a is a xor key and a block holds two
	function automatic block_t block_at(input addr_t b);
		return {(b + 32'd4) ^ 32'h13579bdf, b ^ 32'h13579bdf};
	endfunction

	////////////////////////////////
	// return path
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			refuse       <= 1'b0;
			next_tag     <= 4'd1;
			busy         <= 1'b0;
			wait_cnt     <= 0;
			accept_count <= 0;
			mem2proc_tag <= '0;
		end else begin
			refuse       <= ($urandom % 4) == 0;
			mem2proc_tag <= '0;
			if (mem2proc_response != '0) begin
				// beat shows 2 to 6 cycles after the accepting cycle
				busy         <= 1'b1;
				busy_tag     <= mem2proc_response;
				busy_addr    <= {proc2mem_addr[31:3], 3'b000};
				wait_cnt     <= 1 + ($urandom % 5);
				accept_count <= accept_count + 1;
				// tags run 1 to 15 because zero is reserved
				next_tag     <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end else if (busy) begin
				if (wait_cnt <= 1) begin
					busy          <= 1'b0;
					mem2proc_tag  <= busy_tag;
					mem2proc_data <= block_at(busy_addr);
				end else begin
					wait_cnt <= wait_cnt - 1;
				end
			end
		end
	end

endmodule

// File: tests/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_tb;

	import fetch_pkg::*;

	localparam inst_t inst_key = 32'h13579bdf;

	logic      clock;
	logic      rst;
	logic      stall;
	logic      redirect;
	addr_t     redirect_pc;
	mem_tag_t  mem2proc_response;
	mem_tag_t  mem2proc_tag;
	block_t    mem2proc_data;
	mem_cmd_t  proc2mem_command;
	addr_t     proc2mem_addr;
	logic      if_valid;
	addr_t     if_pc;
	addr_t     if_npc;
	inst_t     if_inst;
	int unsigned accept_count;

	int errors;
	int checks;

	fetch_top u_dut (
		.clock             (clock),
		.rst               (rst),
		.stall             (stall),
		.redirect          (redirect),
		.redirect_pc       (redirect_pc),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.mem2proc_data     (mem2proc_data),
		.proc2mem_command  (proc2mem_command),
		.proc2mem_addr     (proc2mem_addr),
		.if_valid          (if_valid),
		.if_pc             (if_pc),
		.if_npc            (if_npc),
		.if_inst           (if_inst)
	);

	mem_model u_mem_model (
		.clock             (clock),
		.rst               (rst),
		.proc2mem_command  (proc2mem_command),
		.proc2mem_addr     (proc2mem_addr),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.mem2proc_data     (mem2proc_data),
		.accept_count      (accept_count)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// hang guard well above the summed test length
	initial begin
		repeat (4000) @(posedge clock);
		$display("Error: watchdog expired, the fetch unit stopped making progress");
		$display("Checks failed");
		$finish;
	end

	////////////////////////////////
	// helpers
	////////////////////////////////

	// every valid packet must be the next pc in order
	task automatic expect_stream(input addr_t start, input int count);
		addr_t exp_pc;
		int    got;
		int    idle;
		exp_pc = start;
		got = 0;
		idle = 0;
		while (got < count && idle < 200) begin
			@(negedge clock);
			if (if_valid) begin
				checks++;
				assert (if_pc == exp_pc && if_npc == exp_pc + 32'd4
					&& if_inst == (exp_pc ^ inst_key)) else begin
					errors++;
					$display("Mismatch at %0t: pc %h npc %h inst %h, expected pc %h inst %h",
						$time, if_pc, if_npc, if_inst, exp_pc, exp_pc ^ inst_key);
				end
				exp_pc = exp_pc + 32'd4;
				got++;
				idle = 0;
			end else begin
				idle++;
			end
		end
		// a long gap means the stream stalled out
		assert (got == count) else begin
			errors++;
			$display("Error at %0t: no packet %0d of the stream from %h", $time, got, start);
		end
	endtask

	task automatic apply_redirect(input addr_t target);
		@(posedge clock);
		redirect    <= 1'b1;
		redirect_pc <= target;
		@(posedge clock);
		redirect    <= 1'b0;
	endtask

	// memory takes the load on the bus this cycle
	function automatic logic load_taken();
		return proc2mem_command == BUS_LOAD && mem2proc_response != '0;
	endfunction

	// returns in the cycle the memory takes a load
	task automatic wait_accept();
		int n;
		n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (!load_taken() && n < 200);
		assert (load_taken()) else begin
			errors++;
			$display("Error at %0t: no load was accepted", $time);
		end
	endtask

	// same, for a load of one given block
	task automatic wait_accept_at(input addr_t target);
		int n;
		n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (!(load_taken() && proc2mem_addr == target) && n < 200);
		assert (load_taken() && proc2mem_addr == target) else begin
			errors++;
			$display("Error at %0t: no load for %h was accepted", $time, target);
		end
	endtask

	////////////////////////////////
	// tests
	////////////////////////////////

	task automatic test_reset();
		// rst has been high since time zero
		repeat (7) begin
			@(negedge clock);
			checks++;
			assert (!if_valid) else begin
				errors++;
				$display("Mismatch at %0t: if_valid high during reset", $time);
			end
		end
		// eighth rising edge with rst high
		@(posedge clock);
		rst <= 1'b0;
		do begin
			@(negedge clock);
			checks++;
			assert (!if_valid) else begin
				errors++;
				$display("Mismatch at %0t: packet before any fill", $time);
			end
		end while (proc2mem_command != BUS_LOAD);
		checks++;
		assert (proc2mem_addr == `RESET_PC) else begin
			errors++;
			$display("Mismatch at %0t: first load addr %h", $time, proc2mem_addr);
		end
	endtask

	task automatic test_refetch_hits();
		int unsigned base;
		apply_redirect(32'h0);
		// block 0 may have been evicted by the look ahead into 0x100
		expect_stream(32'h0, 2);
		base = accept_count;
		expect_stream(32'h8, 62);
		checks++;
		assert (accept_count == base) else begin
			errors++;
			$display("Mismatch at %0t: %0d loads on a cached path", $time, accept_count - base);
		end
	endtask

	task automatic test_stall_hold();
		logic  ref_valid;
		addr_t ref_pc;
		addr_t ref_npc;
		inst_t ref_inst;
		int    n;
		apply_redirect(32'h2000);
		n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (!if_valid && n < 200);
		@(posedge clock);
		stall <= 1'b1;
		// one more packet lands on the edge that raises stall
		@(negedge clock);
		ref_valid = if_valid;
		ref_pc = if_pc;
		ref_npc = if_npc;
		ref_inst = if_inst;
		checks++;
		assert (ref_valid) else begin
			errors++;
			$display("Error at %0t: no packet on a cached path before the stall", $time);
		end
		repeat (6) begin
			@(negedge clock);
			checks++;
			assert (if_valid == ref_valid && if_pc == ref_pc && if_npc == ref_npc
				&& if_inst == ref_inst) else begin
				errors++;
				$display("Mismatch at %0t: packet moved under stall, pc %h", $time, if_pc);
			end
		end
		@(posedge clock);
		stall <= 1'b0;
		// held packet stays on the outputs through the release cycle
		@(posedge clock);
		expect_stream(ref_pc + 32'd4, 4);
	endtask

	task automatic test_line_replace();
		apply_redirect(32'h0100);
		expect_stream(32'h0100, 2);
		// same index as 0x100 with a different tag
		apply_redirect(32'h0000);
		// a false hit on the old line would never load block 0
		wait_accept_at(32'h0000);
		expect_stream(32'h0000, 2);
	endtask

	initial begin
		void'($urandom(32'hfd68bfa0));
		errors = 0;
		checks = 0;
		rst = 1'b1;
		stall = 1'b0;
		redirect = 1'b0;
		redirect_pc = '0;

		test_reset();
		// cold misses then hits
		expect_stream(`RESET_PC, 64);
		test_refetch_hits();
		// old path must never show
		wait_accept();
		apply_redirect(32'h2000);
		expect_stream(32'h2000, 8);
		test_stall_hold();
		test_line_replace();

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+include
hdl/fetch_pkg.sv
hdl/fetch_stage.sv
hdl/icache_ctrl.sv
hdl/icache_mem.sv
hdl/fetch_top.sv
tests/mem_model.sv
tests/fetch_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
DUT_TOP   ?= fetch_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) +incdir+include \
		hdl/fetch_pkg.sv hdl/fetch_stage.sv hdl/icache_ctrl.sv \
		hdl/icache_mem.sv hdl/fetch_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)
